// ==== source/ulpi_pkg.sv ====
`default_nettype none

package ulpi_pkg;

  // Bus and field widths
  localparam int BYTE_W = 8;
  localparam int PID_W  = 4;
  localparam int ADDR_W = 6;

  typedef logic [BYTE_W-1:0] byte_t;

  // Top two bits of every transmit command byte
  typedef enum logic [1:0] {
    CMD_TX   = 2'b01,
    CMD_REGW = 2'b10
  } cmd_code_e;

  // Data and handshake PIDs sent by this link
  localparam logic [PID_W-1:0] PID_DATA0 = 4'h3;
  localparam logic [PID_W-1:0] PID_DATA1 = 4'hB;
  localparam logic [PID_W-1:0] PID_ACK   = 4'h2;
  localparam logic [PID_W-1:0] PID_NAK   = 4'hA;

  // ULPI line state, SE0 marks end of packet
  typedef logic [1:0] line_state_t;
  localparam line_state_t LS_SE0 = 2'b00;

  // One command byte, read as a transmit-PID or a register-write command
  typedef union packed {
    struct packed {
      cmd_code_e        code;
      logic [1:0]       zero;
      logic [PID_W-1:0] pid;
    } pid;
    struct packed {
      cmd_code_e         code;
      logic [ADDR_W-1:0] addr;
    } regw;
  } tx_cmd_u;

  typedef enum logic [3:0] {
    INIT, REGW, RDATA, IDLE, XPID, DATA, CRC_HI, CRC_LO, DONE, HSK
  } tx_state_e;

endpackage

`default_nettype wire

// ==== source/usb_stream_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface usb_stream_if;
  import ulpi_pkg::*;

  // Byte moves on each edge with valid and ready both high
  logic  valid;
  logic  ready;
  logic  last;
  byte_t data;

  // Producer side
  modport source (
    output valid,
    output last,
    output data,
    input  ready
  );

  // Consumer side
  modport sink (
    input  valid,
    input  last,
    input  data,
    output ready
  );

endinterface

`default_nettype wire

// ==== source/stream_skid.sv ====
`timescale 1ns/10ps
`default_nettype none

module stream_skid #(
  parameter int SKID_DEPTH = 2
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            s_valid_i,
  input  logic            s_last_i,
  input  ulpi_pkg::byte_t s_data_i,
  output logic            s_ready_o,
  usb_stream_if.source    m
);
  import ulpi_pkg::*;

  localparam int CNT_W = $clog2(SKID_DEPTH + 1);

  // Entry 0 is always the head of the queue
  byte_t            data_q [SKID_DEPTH];
  logic             last_q [SKID_DEPTH];
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] wr_idx;
  logic             push;
  logic             pop;

  // Upstream ready from occupancy only, no path back from nxt
  assign s_ready_o = count_q != CNT_W'(SKID_DEPTH);

  assign push = s_valid_i && s_ready_o;
  assign pop  = m.valid && m.ready;

  // A pop shifts everything down one slot before the new byte lands
  assign wr_idx = pop ? count_q - CNT_W'(1) : count_q;

  assign m.valid = count_q != '0;
  assign m.data  = data_q[0];
  assign m.last  = last_q[0];

  always_ff @(posedge clock) begin
    for (int i = 0; i < SKID_DEPTH; i++) begin
      if (push && wr_idx == CNT_W'(i)) begin
        data_q[i] <= s_data_i;
        last_q[i] <= s_last_i;
      end else if (pop && i + 1 < SKID_DEPTH) begin
        // Move up toward the head
        data_q[i] <= data_q[(i + 1 < SKID_DEPTH) ? i + 1 : i];
        last_q[i] <= last_q[(i + 1 < SKID_DEPTH) ? i + 1 : i];
      end
    end
  end

  // Occupancy
  always_ff @(posedge clock) begin
    if (reset) begin
      count_q <= '0;
    end else begin
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

endmodule

`default_nettype wire

// ==== source/usb_crc16.sv ====
`timescale 1ns/10ps
`default_nettype none

module usb_crc16 #(
  parameter logic [15:0] CRC_INIT = 16'hFFFF
) (
  input  logic            clock,
  input  logic            reset,
  input  logic            clear_i,
  input  logic            update_i,
  input  ulpi_pkg::byte_t data_i,
  output ulpi_pkg::byte_t crc_hi_o,
  output ulpi_pkg::byte_t crc_lo_o
);
  import ulpi_pkg::*;

  // x^16 + x^15 + x^2 + 1
  localparam logic [15:0] POLY = 16'h8005;

  logic [15:0] crc_q;

  // Eight serial steps, data LSB first as on the wire
  function automatic logic [15:0] crc_step(input logic [15:0] crc, input byte_t data);
    logic [15:0] acc;
    logic        fb;
    acc = crc;
    for (int i = 0; i < 8; i++) begin
      fb  = acc[15] ^ data[i];
      acc = {acc[14:0], 1'b0};
      if (fb) begin
        acc = acc ^ POLY;
      end
    end
    return acc;
  endfunction

  always_ff @(posedge clock) begin
    if (reset || clear_i) begin
      crc_q <= CRC_INIT;
    end else if (update_i) begin
      crc_q <= crc_step(crc_q, data_i);
    end
  end

  // Complemented and reversed, x^15 term leaves first
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      crc_hi_o[i] = ~crc_q[15 - i];
      crc_lo_o[i] = ~crc_q[7 - i];
    end
  end

endmodule

`default_nettype wire

// ==== source/ulpi_tx_encoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module ulpi_tx_encoder (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         high_speed_i,
  input  logic                         reg_write_i,
  input  logic [ulpi_pkg::ADDR_W-1:0]  reg_addr_i,
  input  ulpi_pkg::byte_t              reg_data_i,
  output logic                         reg_done_o,
  input  logic                         hsk_send_i,
  output logic                         hsk_done_o,
  output logic                         pkt_done_o,
  output logic                         busy_o,
  input  logic [ulpi_pkg::PID_W-1:0]   s_pid_i,
  usb_stream_if.sink                   s,
  output logic                         crc_clear_o,
  output logic                         crc_update_o,
  output ulpi_pkg::byte_t              crc_data_o,
  input  ulpi_pkg::byte_t              crc_hi_i,
  input  ulpi_pkg::byte_t              crc_lo_i,
  input  ulpi_pkg::line_state_t        line_state_i,
  input  logic                         ulpi_dir_i,
  input  logic                         ulpi_nxt_i,
  output logic                         ulpi_stp_o,
  output ulpi_pkg::byte_t              ulpi_data_o
);
  import ulpi_pkg::*;

  // Output byte sources
  localparam logic [1:0] SEL_CMD = 2'd0;
  localparam logic [1:0] SEL_PAY = 2'd1;
  localparam logic [1:0] SEL_CRC = 2'd2;
  localparam logic [1:0] SEL_REG = 2'd3;

  tx_state_e  state_q, state_d;
  tx_cmd_u    cmd_w;
  byte_t      data_q, reg_data_q, sel_byte;
  logic [1:0] sel;
  logic       load, stp_d, hsk_done_d;
  logic       hold, pop, eop;
  logic       dir_q, stp_q, reg_done_q, hsk_done_q, pkt_done_q;
  logic       out_valid_q, out_last_q;

  // PHY owns the bus, or is handing it back
  assign hold = ulpi_dir_i || dir_q;

  // End of packet seen after at least one turnaround cycle
  assign eop = state_q == DONE && ulpi_dir_i && dir_q && !ulpi_nxt_i &&
               line_state_i == LS_SE0;

  // Pull a payload byte when nxt takes the output register, or it ran empty
  assign s.ready = !hold &&
                   ((state_q == XPID && ulpi_nxt_i) ||
                    (state_q == DATA && !out_last_q && (ulpi_nxt_i || !out_valid_q)));
  assign pop = s.valid && s.ready;

  // CRC runs over every payload byte taken from the skid buffer
  assign crc_clear_o  = state_q == IDLE;
  assign crc_update_o = pop;
  assign crc_data_o   = s.data;

  assign ulpi_data_o = data_q;
  assign ulpi_stp_o  = stp_q;
  assign reg_done_o  = reg_done_q;
  assign hsk_done_o  = hsk_done_q;
  assign pkt_done_o  = pkt_done_q;
  assign busy_o      = stp_q || !(state_q == INIT || state_q == IDLE);

  // Command byte, register write during INIT and transmit PID afterwards
  always_comb begin
    cmd_w = '0;
    if (state_q == INIT) begin
      cmd_w.regw.code = CMD_REGW;
      cmd_w.regw.addr = reg_addr_i;
    end else begin
      cmd_w.pid.code = CMD_TX;
      cmd_w.pid.zero = 2'b00;
      cmd_w.pid.pid  = s_pid_i;
    end
  end

  // Four-way byte selector feeding the output register
  always_comb begin
    case (sel)
      SEL_CMD: sel_byte = cmd_w;
      SEL_PAY: sel_byte = s.data;
      // First CRC byte leaves DATA, second leaves CRC_HI
      SEL_CRC: sel_byte = (state_q == DATA) ? crc_hi_i : crc_lo_i;
      // Register data after the command, zero for the stp cycle
      default: sel_byte = (state_q == REGW) ? reg_data_q : '0;
    endcase
  end

  always_comb begin
    state_d    = state_q;
    load       = 1'b0;
    sel        = SEL_REG;
    stp_d      = 1'b0;
    hsk_done_d = 1'b0;
    case (state_q)
      INIT: begin
        if (high_speed_i) begin
          state_d = IDLE;
        end else if (reg_write_i && !stp_q) begin
          state_d = REGW;
          load    = 1'b1;
          sel     = SEL_CMD;
        end
      end
      REGW: begin
        if (ulpi_nxt_i) begin
          state_d = RDATA;
          load    = 1'b1;
        end
      end
      RDATA: begin
        if (ulpi_nxt_i) begin
          state_d = INIT;
          load    = 1'b1;
          stp_d   = 1'b1;
        end
      end
      IDLE: begin
        // Handshakes win over a waiting packet
        if (!stp_q && hsk_send_i) begin
          state_d = HSK;
          load    = 1'b1;
          sel     = SEL_CMD;
        end else if (!stp_q && s.valid) begin
          state_d = XPID;
          load    = 1'b1;
          sel     = SEL_CMD;
        end
      end
      HSK: begin
        if (ulpi_nxt_i) begin
          state_d    = IDLE;
          load       = 1'b1;
          stp_d      = 1'b1;
          hsk_done_d = 1'b1;
        end
      end
      XPID: begin
        // First payload byte replaces the PID as it is taken
        if (ulpi_nxt_i) begin
          state_d = DATA;
          load    = 1'b1;
          sel     = SEL_PAY;
        end
      end
      DATA: begin
        if (ulpi_nxt_i && out_last_q) begin
          state_d = CRC_HI;
          load    = 1'b1;
          sel     = SEL_CRC;
        end else if (pop) begin
          load = 1'b1;
          sel  = SEL_PAY;
        end
      end
      CRC_HI: begin
        if (ulpi_nxt_i) begin
          state_d = CRC_LO;
          load    = 1'b1;
          sel     = SEL_CRC;
        end
      end
      CRC_LO: begin
        if (ulpi_nxt_i) begin
          state_d = DONE;
          load    = 1'b1;
          stp_d   = 1'b1;
        end
      end
      default: begin
        // DONE only leaves on eop below
        state_d = state_q;
      end
    endcase
    // Freeze while the PHY has the bus
    if (hold) begin
      state_d    = state_q;
      load       = 1'b0;
      stp_d      = 1'b0;
      hsk_done_d = 1'b0;
    end
    if (eop) begin
      state_d = IDLE;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q    <= INIT;
      dir_q      <= 1'b0;
      stp_q      <= 1'b0;
      data_q     <= '0;
      reg_done_q <= 1'b0;
      hsk_done_q <= 1'b0;
      pkt_done_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      dir_q      <= ulpi_dir_i;
      stp_q      <= stp_d;
      // Register write completes one cycle after its stp
      reg_done_q <= stp_q && state_q == INIT;
      hsk_done_q <= hsk_done_d;
      pkt_done_q <= eop;
      if (load) begin
        data_q <= sel_byte;
      end
    end
  end

  // Tracks whether the output register holds an unsent payload byte
  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid_q <= 1'b0;
      out_last_q  <= 1'b0;
    end else if (pop) begin
      out_valid_q <= 1'b1;
      out_last_q  <= s.last;
    end else if (!hold && state_q == DATA && ulpi_nxt_i) begin
      out_valid_q <= 1'b0;
    end
  end

  // Data byte captured with the command
  always_ff @(posedge clock) begin
    if (state_q == INIT && load) begin
      reg_data_q <= reg_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== source/ulpi_tx_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module ulpi_tx_top #(
  parameter int          SKID_DEPTH = 2,
  parameter logic [15:0] CRC_INIT   = 16'hFFFF
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         high_speed_i,
  input  logic                         reg_write_i,
  input  logic [ulpi_pkg::ADDR_W-1:0]  reg_addr_i,
  input  ulpi_pkg::byte_t              reg_data_i,
  output logic                         reg_done_o,
  input  logic                         hsk_send_i,
  output logic                         hsk_done_o,
  output logic                         pkt_done_o,
  output logic                         busy_o,
  input  logic                         s_valid_i,
  input  logic                         s_last_i,
  input  ulpi_pkg::byte_t              s_data_i,
  output logic                         s_ready_o,
  input  logic [ulpi_pkg::PID_W-1:0]   s_pid_i,
  input  ulpi_pkg::line_state_t        line_state_i,
  input  logic                         ulpi_dir_i,
  input  logic                         ulpi_nxt_i,
  output logic                         ulpi_stp_o,
  output ulpi_pkg::byte_t              ulpi_data_o
);
  import ulpi_pkg::*;

  usb_stream_if stream ();

  byte_t crc_data, crc_hi, crc_lo;
  logic  crc_clear, crc_update;
  logic  link_up_q, skid_ready;

  // Stream is closed until high speed, and stays open after that
  always_ff @(posedge clock) begin
    if (reset) begin
      link_up_q <= 1'b0;
    end else if (high_speed_i) begin
      link_up_q <= 1'b1;
    end
  end

  assign s_ready_o = skid_ready && link_up_q;

  stream_skid #(
    .SKID_DEPTH(SKID_DEPTH)
  ) u_skid (
    .clock    (clock),
    .reset    (reset),
    .s_valid_i(s_valid_i && link_up_q),
    .s_last_i (s_last_i),
    .s_data_i (s_data_i),
    .s_ready_o(skid_ready),
    .m        (stream)
  );

  usb_crc16 #(
    .CRC_INIT(CRC_INIT)
  ) u_crc (
    .clock   (clock),
    .reset   (reset),
    .clear_i (crc_clear),
    .update_i(crc_update),
    .data_i  (crc_data),
    .crc_hi_o(crc_hi),
    .crc_lo_o(crc_lo)
  );

  ulpi_tx_encoder u_enc (
    .clock       (clock),
    .reset       (reset),
    .high_speed_i(high_speed_i),
    .reg_write_i (reg_write_i),
    .reg_addr_i  (reg_addr_i),
    .reg_data_i  (reg_data_i),
    .reg_done_o  (reg_done_o),
    .hsk_send_i  (hsk_send_i),
    .hsk_done_o  (hsk_done_o),
    .pkt_done_o  (pkt_done_o),
    .busy_o      (busy_o),
    .s_pid_i     (s_pid_i),
    .s           (stream),
    .crc_clear_o (crc_clear),
    .crc_update_o(crc_update),
    .crc_data_o  (crc_data),
    .crc_hi_i    (crc_hi),
    .crc_lo_i    (crc_lo),
    .line_state_i(line_state_i),
    .ulpi_dir_i  (ulpi_dir_i),
    .ulpi_nxt_i  (ulpi_nxt_i),
    .ulpi_stp_o  (ulpi_stp_o),
    .ulpi_data_o (ulpi_data_o)
  );

endmodule

`default_nettype wire

// ==== dv/ulpi_tx_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module ulpi_tx_sva (
  input logic                clock,
  input logic                reset,
  input logic                ulpi_dir_i,
  input logic                ulpi_nxt_i,
  input logic                ulpi_stp_o,
  input ulpi_pkg::byte_t     ulpi_data_o,
  input ulpi_pkg::tx_state_e state_q,
  input logic                out_valid_q
);
  import ulpi_pkg::*;

  logic sending;

  // States where the output byte only moves on nxt
  assign sending = state_q inside {REGW, RDATA, HSK, XPID, CRC_HI, CRC_LO} ||
                   (state_q == DATA && out_valid_q);

  // stp lasts one cycle
  a_stp_single: assert property (@(posedge clock) disable iff (reset)
    ulpi_stp_o |=> !ulpi_stp_o)
    else $error("stp high for two cycles");

  // Link never stops while the PHY owns the bus
  a_stp_no_dir: assert property (@(posedge clock) disable iff (reset)
    ulpi_stp_o |-> !ulpi_dir_i)
    else $error("stp high while dir high");

  a_stp_zero: assert property (@(posedge clock) disable iff (reset)
    ulpi_stp_o |-> ulpi_data_o == '0)
    else $error("data bus not zero in stp cycle");

  // Byte waits for the PHY
  a_hold: assert property (@(posedge clock) disable iff (reset)
    (sending && !ulpi_nxt_i) |=> $stable(ulpi_data_o))
    else $error("data bus changed while nxt low");

endmodule

bind ulpi_tx_encoder ulpi_tx_sva u_sva (
  .clock      (clock),
  .reset      (reset),
  .ulpi_dir_i (ulpi_dir_i),
  .ulpi_nxt_i (ulpi_nxt_i),
  .ulpi_stp_o (ulpi_stp_o),
  .ulpi_data_o(ulpi_data_o),
  .state_q    (state_q),
  .out_valid_q(out_valid_q)
);

`default_nettype wire

// ==== dv/ulpi_tx_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module ulpi_tx_tb;
  import ulpi_pkg::*;

  logic        clock, reset, high_speed_i, reg_write_i, hsk_send_i;
  logic [5:0]  reg_addr_i;
  byte_t       reg_data_i, s_data_i, ulpi_data_o;
  logic        reg_done_o, hsk_done_o, pkt_done_o, busy_o;
  logic        s_valid_i, s_last_i, s_ready_o;
  logic [3:0]  s_pid_i;
  line_state_t line_state_i;
  logic        ulpi_dir_i, ulpi_nxt_i, ulpi_stp_o, dir_prev;

  int    seed = 32'h51e3;
  int    errors = 0;
  int    nreq = 0;
  int    pushed;
  byte_t got[$];
  int    kind[16], arg[16], flag[16], plen[16], elen[16];
  byte_t pay[16][4];
  byte_t exp_b[16][7];

  ulpi_tx_top #(.SKID_DEPTH(2), .CRC_INIT(16'hFFFF)) u_dut (.*);

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // PHY side record of accepted bytes and upstream transfers
  always @(posedge clock) begin
    if (!reset) begin
      if (ulpi_nxt_i && !ulpi_dir_i && !dir_prev && busy_o && !ulpi_stp_o) begin
        got.push_back(ulpi_data_o);
      end
      if (s_valid_i && s_ready_o) begin
        pushed++;
      end
    end
    dir_prev <= ulpi_dir_i;
  end

  task automatic check_value(input string name, input logic [31:0] expv,
                             input logic [31:0] act);
    if (expv !== act) begin
      errors++;
      $display("ERROR %s: expected %0h, actual %0h", name, expv, act);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic load_tests();
    int    fd;
    int    cnt;
    int    f[16];
    string line;
    fd = $fopen("dv/ulpi_tx_testdata.txt", "r");
    if (fd == 0) begin
      $display("Cannot open dv/ulpi_tx_testdata.txt");
      $display("Simulation FAILED");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") continue;
      cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                    f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
      if (cnt != 16) continue;
      kind[nreq] = f[0];
      arg[nreq]  = f[1];
      flag[nreq] = f[2];
      plen[nreq] = f[3];
      elen[nreq] = f[8];
      for (int i = 0; i < 4; i++) pay[nreq][i] = f[4 + i][7:0];
      for (int i = 0; i < 7; i++) exp_b[nreq][i] = f[9 + i][7:0];
      nreq++;
    end
    $fclose(fd);
  endtask

  // Drives stream and random nxt each falling edge until stp shows up
  task automatic run_phy(input int t);
    int  stall;
    int  r;
    bit  paused;
    stall  = 0;
    paused = 0;
    forever begin
      @(negedge clock);
      if (ulpi_stp_o) begin
        ulpi_nxt_i = 1'b0;
        s_valid_i  = 1'b0;
        break;
      end
      s_valid_i = pushed < plen[t];
      s_data_i  = pay[t][(pushed < plen[t]) ? pushed : 0];
      s_last_i  = pushed == plen[t] - 1;
      // Mid-packet bus turnaround or a long nxt gap
      if (flag[t] != 0 && !paused && got.size() >= 2) begin
        paused = 1;
        stall  = (flag[t] == 1) ? 4 : 16;
      end
      if (stall > 0) begin
        stall--;
        ulpi_dir_i = (flag[t] == 1) && (stall > 0);
        ulpi_nxt_i = 1'b0;
      end else begin
        ulpi_dir_i = 1'b0;
        r = $random(seed);
        ulpi_nxt_i = busy_o && r[0];
      end
    end
  endtask

  initial begin
    string name;
    bit    hs_up;
    reset = 1'b1;
    high_speed_i = 1'b0;
    reg_write_i = 1'b0;
    hsk_send_i = 1'b0;
    reg_addr_i = '0;
    reg_data_i = '0;
    s_valid_i = 1'b0;
    s_last_i = 1'b0;
    s_data_i = '0;
    s_pid_i = '0;
    line_state_i = 2'b01;
    ulpi_dir_i = 1'b0;
    ulpi_nxt_i = 1'b0;
    hs_up = 0;
    load_tests();
    fork
      begin
        #(nreq * 200 * 40 + 2000);
        $display("Watchdog expired before all requests finished");
        $display("Simulation FAILED");
        $fatal(1);
      end
    join_none
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    // Quiet outputs before any request
    repeat (3) begin
      @(negedge clock);
      check_value("reset outputs", 0, {s_ready_o, ulpi_stp_o, reg_done_o,
                                       hsk_done_o, pkt_done_o, busy_o});
      check_value("reset data", 0, ulpi_data_o);
    end
    for (int t = 0; t < nreq; t++) begin
      name = $sformatf("req%0d", t);
      got.delete();
      pushed = 0;
      if (kind[t] != 0 && !hs_up) begin
        @(negedge clock);
        high_speed_i = 1'b1;
        @(negedge clock);
        high_speed_i = 1'b0;
        hs_up = 1;
      end
      @(negedge clock);
      s_pid_i = arg[t][3:0];
      if (kind[t] == 0) begin
        reg_addr_i  = arg[t][5:0];
        reg_data_i  = pay[t][0];
        reg_write_i = 1'b1;
      end else if (kind[t] == 1) begin
        hsk_send_i = 1'b1;
      end
      @(negedge clock);
      reg_write_i = 1'b0;
      hsk_send_i  = 1'b0;
      run_phy(t);
      if (kind[t] == 0) begin
        check_value({name, " reg_done early"}, 0, reg_done_o);
        @(negedge clock);
        check_value({name, " reg_done"}, 1, reg_done_o);
      end else if (kind[t] == 1) begin
        check_value({name, " hsk_done"}, 1, hsk_done_o);
      end else begin
        @(negedge clock);
        ulpi_dir_i = 1'b1;
        // Turnaround and a few more cycles of dir without SE0
        repeat (3) begin
          @(negedge clock);
          check_value({name, " pkt_done before SE0"}, 0, pkt_done_o);
        end
        line_state_i = LS_SE0;
        do @(negedge clock); while (!pkt_done_o);
        ulpi_dir_i   = 1'b0;
        line_state_i = 2'b01;
        check_value({name, " upstream bytes"}, plen[t], pushed);
      end
      check_value({name, " byte count"}, elen[t], got.size());
      // Command byte rebuilt from the request fields
      if (kind[t] == 0) begin
        check_value({name, " command"}, {CMD_REGW, arg[t][5:0]}, got[0]);
      end else begin
        check_value({name, " command"}, {CMD_TX, 2'b00, arg[t][3:0]}, got[0]);
      end
      for (int i = 0; i < elen[t]; i++) begin
        check_value($sformatf("%s byte %0d", name, i), exp_b[t][i], got[i]);
      end
      // Done strobes are single pulses and the link is idle again
      repeat (3) begin
        @(negedge clock);
        check_value({name, " idle outputs"}, 0, {ulpi_stp_o, reg_done_o,
                                                 hsk_done_o, pkt_done_o, busy_o});
      end
    end
    if (errors == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("Simulation FAILED");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
source/ulpi_pkg.sv
source/usb_stream_if.sv
source/stream_skid.sv
source/usb_crc16.sv
source/ulpi_tx_encoder.sv
source/ulpi_tx_top.sv
dv/ulpi_tx_sva.sv
dv/ulpi_tx_tb.sv

// ==== dv/ulpi_tx_testdata.txt ====
# kind arg flag n p0 p1 p2 p3 m e0 e1 e2 e3 e4 e5 e6 (hex)
# kind 0 reg write (p0 = data), 1 handshake, 2 packet; flag 1 dir pause, 2 long nxt stall
0 0A 0 1 5C 00 00 00 2 8A 5C 00 00 00 00 00
0 2F 0 1 A5 00 00 00 2 AF A5 00 00 00 00 00
1 2 0 0 00 00 00 00 1 42 00 00 00 00 00 00
1 A 0 0 00 00 00 00 1 4A 00 00 00 00 00 00
2 3 0 1 00 00 00 00 4 43 00 40 BF 00 00 00
2 B 0 4 00 01 02 03 7 4B 00 01 02 03 EF 7A
2 3 1 4 00 01 02 03 7 43 00 01 02 03 EF 7A
2 B 2 4 00 01 02 03 7 4B 00 01 02 03 EF 7A
1 2 0 0 00 00 00 00 1 42 00 00 00 00 00 00
2 3 1 1 00 00 00 00 4 43 00 40 BF 00 00 00
